// ==== logic/cpuCorePkg.sv ====
`default_nettype none

package cpuCorePkg;

  // Data and address word
  typedef logic [31:0] wordT;

  // Sequencer modes, one instruction at a time
  typedef enum logic [2:0] {
    fetchIssue,
    fetchWait,
    decodeRead,
    constWait,
    memIssue,
    memWait,
    finish
  } seqModeT;

  // RAM access made by the current instruction
  typedef enum logic [1:0] {
    memNone,
    memRead,
    memWrite
  } memKindT;

endpackage

`default_nettype wire

// ==== logic/cpuIsaPkg.sv ====
`default_nettype none

package cpuIsaPkg;

  // Eight-bit opcode space
  // Zero and every unlisted code retire as a no-op
  typedef enum logic [7:0] {
    opMovRC     = 8'h01,
    opMovRR     = 8'h02,
    opMovRdC    = 8'h03,
    opMovRdR    = 8'h04,
    opMovRdRo   = 8'h05,
    opMovdCR    = 8'h06,
    opMovdRoR   = 8'h07,
    opPushR     = 8'h08,
    opPopR      = 8'h09,
    opCallR     = 8'h0A,
    opRet       = 8'h0B,
    opCmpRR     = 8'h0C,
    opCmpRC     = 8'h0D,
    opJmpC      = 8'h0E,
    opJneC      = 8'h0F,
    opAddRC     = 8'h10,
    opAddRR     = 8'h11,
    opIncR      = 8'h12,
    opDecR      = 8'h13,
    opMulAddRRC = 8'h14,
    opDoutR     = 8'h15
  } opcodeT;

  // Instruction word, opcode in the low byte
  typedef struct packed {
    logic [7:0] auxField;
    logic [7:0] srcField;
    logic [7:0] dstField;
    opcodeT     opcode;
  } instrT;

  // Fixed register roles
  localparam int stackPtrReg = 0;
  localparam int flagsReg = 1;

  // Compare flag bits in the flags register
  localparam int flagEqualBit = 0;
  localparam int flagLessBit = 1;
  localparam int flagGreaterBit = 2;

  // Byte steps for stack and instruction pointer
  localparam int unsigned stackStep = 4;
  localparam int unsigned instrBytes = 4;
  localparam int unsigned wideInstrBytes = 8;

endpackage

`default_nettype wire

// ==== logic/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer import cpuCorePkg::*, cpuIsaPkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire wordT    ramIn,
  input  wire          readAck,
  input  wire          writeAck,
  input  wire opcodeT  opcode,
  input  wire          isWide,
  input  wire memKindT memKind,
  input  wire wordT    memAddress,
  input  wire wordT    memData,
  input  wire          jumpTaken,
  input  wire wordT    jumpTarget,
  output wordT         ramAddress,
  output wordT         ramOut,
  output logic         readReq,
  output logic         writeReq,
  output logic         instrLoad,
  output logic         operandLoad,
  output logic         finishStrobe,
  output wordT         constWord,
  output wordT         loadedWord,
  output wordT         ipointer
);

  seqModeT mode;
  wordT    fallThrough;
  logic    memDone;

  // Decoder grabs the word on the fetch acknowledge
  assign instrLoad = (mode == fetchWait) && readAck;
  // Register file outputs are settled by decodeRead
  assign operandLoad = (mode == decodeRead);
  assign finishStrobe = (mode == finish);

  // Wide instructions skip their trailing constant
  assign fallThrough = ipointer + (isWide ? wideInstrBytes : instrBytes);

  // Data phase ends on the acknowledge matching the request kind
  assign memDone = ((memKind == memRead) && readAck) || ((memKind == memWrite) && writeAck);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode     <= fetchIssue;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      ipointer <= '0;
    end
    else
    begin
      case (mode)
        fetchIssue:
        begin
          readReq <= 1'b1;
          mode    <= fetchWait;
        end
        fetchWait:
        begin
          readReq <= 1'b0;
          if (readAck)
            mode <= decodeRead;
        end
        decodeRead:
        begin
          // Constant word comes first, then any data access
          if (isWide)
          begin
            readReq <= 1'b1;
            mode    <= constWait;
          end
          else if (memKind != memNone)
            mode <= memIssue;
          else
            mode <= finish;
        end
        constWait:
        begin
          readReq <= 1'b0;
          if (readAck)
            mode <= (memKind != memNone) ? memIssue : finish;
        end
        memIssue:
        begin
          readReq  <= (memKind == memRead);
          writeReq <= (memKind == memWrite);
          mode     <= memWait;
        end
        memWait:
        begin
          readReq  <= 1'b0;
          writeReq <= 1'b0;
          // No timeout, a slow RAM just stretches this mode
          if (memDone)
            mode <= finish;
        end
        finish:
        begin
          ipointer <= jumpTaken ? jumpTarget : fallThrough;
          mode     <= fetchIssue;
        end
        default:
          mode <= fetchIssue;
      endcase
    end
  end

  // Bus address and data, plus captured RAM words
  always_ff @(posedge clk)
  begin
    if (mode == fetchIssue)
      ramAddress <= ipointer;
    // Constant sits right after the instruction word
    if ((mode == decodeRead) && isWide)
      ramAddress <= ipointer + instrBytes;
    if (mode == memIssue)
    begin
      ramAddress <= memAddress;
      ramOut     <= memData;
    end
    if ((mode == constWait) && readAck)
      constWord <= ramIn;
    if ((mode == memWait) && (memKind == memRead) && readAck)
      loadedWord <= ramIn;
  end

endmodule

`default_nettype wire

// ==== logic/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder import cpuCorePkg::*, cpuIsaPkg::*;
#(
  parameter  int regCount = 16,
  localparam int idxBits = $clog2(regCount)
)
(
  input  wire               clk,
  input  wire               reset,
  input  wire wordT         ramIn,
  input  wire               instrLoad,
  output opcodeT            opcode,
  output logic [idxBits-1:0] dstIdx,
  output logic [idxBits-1:0] srcIdx,
  output logic [idxBits-1:0] auxIdx,
  output logic              isWide,
  output memKindT           memKind
);

  instrT instrWord;

  // Held for the whole instruction
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      instrWord <= '0;
    else if (instrLoad)
      instrWord <= instrT'(ramIn);
  end

  assign opcode = instrWord.opcode;

  // Register fields name registers directly, low bits only
  assign dstIdx = instrWord.dstField[idxBits-1:0];
  assign srcIdx = instrWord.srcField[idxBits-1:0];
  assign auxIdx = instrWord.auxField[idxBits-1:0];

  // Width class and RAM access per opcode
  always_comb
  begin
    isWide  = 1'b0;
    memKind = memNone;
    case (instrWord.opcode)
      opMovRC, opCmpRC, opJmpC, opJneC, opAddRC, opMulAddRRC:
        isWide = 1'b1;
      opMovRdC, opMovRdRo:
      begin
        isWide  = 1'b1;
        memKind = memRead;
      end
      opMovdCR, opMovdRoR:
      begin
        isWide  = 1'b1;
        memKind = memWrite;
      end
      // Stack pops and plain register loads
      opMovRdR, opPopR, opRet:
        memKind = memRead;
      opPushR, opCallR:
        memKind = memWrite;
      default:
        isWide = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuCorePkg::*, cpuIsaPkg::*;
#(
  parameter  int regCount = 16,
  localparam int idxBits = $clog2(regCount)
)
(
  input  wire               clk,
  input  wire               reset,
  input  wire [idxBits-1:0] dstIdx,
  input  wire [idxBits-1:0] srcIdx,
  input  wire [idxBits-1:0] auxIdx,
  input  wire               resultWe,
  input  wire wordT         resultData,
  input  wire               flagsWe,
  input  wire wordT         flagsData,
  input  wire               spWe,
  input  wire wordT         spData,
  output wordT              dstValue,
  output wordT              srcValue,
  output wordT              auxValue,
  output wordT              stackPtr,
  output wordT              flags
);

  wordT regs [regCount];

  // Three operand read ports, combinational
  assign dstValue = regs[dstIdx];
  assign srcValue = regs[srcIdx];
  assign auxValue = regs[auxIdx];

  // Dedicated views of the stack pointer and compare flags
  assign stackPtr = regs[stackPtrReg];
  assign flags = regs[flagsReg];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < regCount; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (spWe)
        regs[stackPtrReg] <= spData;
      if (flagsWe)
        regs[flagsReg] <= flagsData;
      // Last assignment wins
      // PopR into register 0 keeps the popped value
      if (resultWe)
        regs[dstIdx] <= resultData;
    end
  end

endmodule

`default_nettype wire

// ==== logic/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit import cpuCorePkg::*, cpuIsaPkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         operandLoad,
  input  wire         finishStrobe,
  input  wire opcodeT opcode,
  input  wire wordT   dstValue,
  input  wire wordT   srcValue,
  input  wire wordT   auxValue,
  input  wire wordT   stackPtr,
  input  wire wordT   flags,
  input  wire wordT   constWord,
  input  wire wordT   loadedWord,
  input  wire wordT   ipointer,
  output wordT        memAddress,
  output wordT        memData,
  output logic        resultWe,
  output wordT        resultData,
  output logic        flagsWe,
  output wordT        flagsData,
  output logic        spWe,
  output wordT        spData,
  output logic        jumpTaken,
  output wordT        jumpTarget,
  output logic        doutValid,
  output wordT        doutData
);

  wordT dstOperand;
  wordT srcOperand;
  wordT compareRhs;
  logic writesResult;
  logic branches;

  // Operands frozen at decodeRead
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      dstOperand <= '0;
      srcOperand <= '0;
    end
    else if (operandLoad)
    begin
      dstOperand <= dstValue;
      srcOperand <= srcValue;
    end
  end

  // RAM address and store data for the data phase
  always_comb
  begin
    memAddress = constWord;
    memData    = srcOperand;
    case (opcode)
      opMovRdR:            memAddress = srcOperand;
      opMovRdRo:           memAddress = constWord + srcOperand;
      opMovdRoR:           memAddress = constWord + dstOperand;
      opPopR, opRet:       memAddress = stackPtr - stackStep;
      opPushR:
      begin
        memAddress = stackPtr;
        memData    = dstOperand;
      end
      // Return address is the call's own address
      opCallR:
      begin
        memAddress = stackPtr;
        memData    = ipointer;
      end
      default:             memAddress = constWord;
    endcase
  end

  // Register result
  always_comb
  begin
    writesResult = 1'b1;
    resultData   = loadedWord;
    case (opcode)
      opMovRC:     resultData = constWord;
      opMovRR:     resultData = srcOperand;
      opMovRdC, opMovRdR, opMovRdRo, opPopR:
                   resultData = loadedWord;
      opAddRC:     resultData = dstOperand + constWord;
      opAddRR:     resultData = dstOperand + srcOperand;
      opIncR:      resultData = dstOperand + 1;
      opDecR:      resultData = dstOperand - 1;
      // Low 32 bits of the product
      opMulAddRRC: resultData = dstOperand + srcOperand * constWord;
      default:     writesResult = 1'b0;
    endcase
  end

  // Unsigned compare against a register or the constant
  assign compareRhs = (opcode == opCmpRC) ? constWord : srcOperand;
  always_comb
  begin
    flagsData = '0;
    flagsData[flagEqualBit] = (dstOperand == compareRhs);
    flagsData[flagLessBit] = (dstOperand < compareRhs);
    flagsData[flagGreaterBit] = (dstOperand > compareRhs);
  end

  // Push and call grow the stack, pop and return shrink it
  assign spData = ((opcode == opPushR) || (opcode == opCallR)) ? stackPtr + stackStep
                                                               : stackPtr - stackStep;

  // Control transfers
  always_comb
  begin
    branches   = 1'b1;
    jumpTarget = constWord;
    case (opcode)
      opJmpC:  jumpTarget = constWord;
      // Taken only when the last compare was not equal
      opJneC:  branches = ~flags[flagEqualBit];
      opCallR: jumpTarget = dstOperand;
      opRet:   jumpTarget = loadedWord + instrBytes;
      default: branches = 1'b0;
    endcase
  end

  // Everything architectural lands at the end of finish
  assign resultWe = finishStrobe && writesResult;
  assign flagsWe = finishStrobe && ((opcode == opCmpRR) || (opcode == opCmpRC));
  assign spWe = finishStrobe && ((opcode == opPushR) || (opcode == opPopR) ||
                                 (opcode == opCallR) || (opcode == opRet));
  assign jumpTaken = finishStrobe && branches;

  // Output strobe for DoutR
  assign doutValid = finishStrobe && (opcode == opDoutR);
  assign doutData = dstOperand;

endmodule

`default_nettype wire

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuCorePkg::*, cpuIsaPkg::*;
#(
  parameter int regCount = 16
)
(
  input  wire       clk,
  input  wire       reset,
  input  wire wordT ramIn,
  input  wire       readAck,
  input  wire       writeAck,
  output wordT      ramAddress,
  output wordT      ramOut,
  output logic      readReq,
  output logic      writeReq,
  output logic      doutValid,
  output wordT      doutData
);

  localparam int idxBits = $clog2(regCount);

  // Sequencer strobes
  logic instrLoad;
  logic operandLoad;
  logic finishStrobe;

  // Decoded instruction
  opcodeT             opcode;
  logic [idxBits-1:0] dstIdx;
  logic [idxBits-1:0] srcIdx;
  logic [idxBits-1:0] auxIdx;
  logic               isWide;
  memKindT            memKind;

  // Register read side
  wordT dstValue;
  wordT srcValue;
  wordT auxValue;
  wordT stackPtr;
  wordT flags;

  // Captured words and pointer
  wordT constWord;
  wordT loadedWord;
  wordT ipointer;

  // Execute results
  wordT memAddress;
  wordT memData;
  logic resultWe;
  wordT resultData;
  logic flagsWe;
  wordT flagsData;
  logic spWe;
  wordT spData;
  logic jumpTaken;
  wordT jumpTarget;

  controlSequencer sequencer (
    .clk(clk),
    .reset(reset),
    .ramIn(ramIn),
    .readAck(readAck),
    .writeAck(writeAck),
    .opcode(opcode),
    .isWide(isWide),
    .memKind(memKind),
    .memAddress(memAddress),
    .memData(memData),
    .jumpTaken(jumpTaken),
    .jumpTarget(jumpTarget),
    .ramAddress(ramAddress),
    .ramOut(ramOut),
    .readReq(readReq),
    .writeReq(writeReq),
    .instrLoad(instrLoad),
    .operandLoad(operandLoad),
    .finishStrobe(finishStrobe),
    .constWord(constWord),
    .loadedWord(loadedWord),
    .ipointer(ipointer)
  );

  instructionDecoder #(
    .regCount(regCount)
  ) decoder (
    .clk(clk),
    .reset(reset),
    .ramIn(ramIn),
    .instrLoad(instrLoad),
    .opcode(opcode),
    .dstIdx(dstIdx),
    .srcIdx(srcIdx),
    .auxIdx(auxIdx),
    .isWide(isWide),
    .memKind(memKind)
  );

  registerFile #(
    .regCount(regCount)
  ) regFile (
    .clk(clk),
    .reset(reset),
    .dstIdx(dstIdx),
    .srcIdx(srcIdx),
    .auxIdx(auxIdx),
    .resultWe(resultWe),
    .resultData(resultData),
    .flagsWe(flagsWe),
    .flagsData(flagsData),
    .spWe(spWe),
    .spData(spData),
    .dstValue(dstValue),
    .srcValue(srcValue),
    .auxValue(auxValue),
    .stackPtr(stackPtr),
    .flags(flags)
  );

  executeUnit execute (
    .clk(clk),
    .reset(reset),
    .operandLoad(operandLoad),
    .finishStrobe(finishStrobe),
    .opcode(opcode),
    .dstValue(dstValue),
    .srcValue(srcValue),
    .auxValue(auxValue),
    .stackPtr(stackPtr),
    .flags(flags),
    .constWord(constWord),
    .loadedWord(loadedWord),
    .ipointer(ipointer),
    .memAddress(memAddress),
    .memData(memData),
    .resultWe(resultWe),
    .resultData(resultData),
    .flagsWe(flagsWe),
    .flagsData(flagsData),
    .spWe(spWe),
    .spData(spData),
    .jumpTaken(jumpTaken),
    .jumpTarget(jumpTarget),
    .doutValid(doutValid),
    .doutData(doutData)
  );

endmodule

`default_nettype wire

// ==== dv/cpuCore_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreAssertions
(
  input wire clk,
  input wire reset,
  input wire readReq,
  input wire writeReq,
  input wire readAck,
  input wire writeAck,
  input wire doutValid
);

  logic outstanding;

  // Set by a request, cleared by its acknowledge
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      outstanding <= 1'b0;
    else if (readReq || writeReq)
      outstanding <= 1'b1;
    else if (readAck || writeAck)
      outstanding <= 1'b0;
  end

  // Never a read and a write at once
  reqExclusive: assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq))
    else $error("readReq and writeReq high in the same cycle");

  // Requests are single-cycle pulses
  readPulse: assert property (@(posedge clk) disable iff (reset) readReq |=> !readReq)
    else $error("readReq held longer than one cycle");
  writePulse: assert property (@(posedge clk) disable iff (reset) writeReq |=> !writeReq)
    else $error("writeReq held longer than one cycle");

  // DoutR strobe
  doutPulse: assert property (@(posedge clk) disable iff (reset) doutValid |=> !doutValid)
    else $error("doutValid held longer than one cycle");

  // One request in flight at most
  singleOutstanding: assert property (@(posedge clk) disable iff (reset)
    (readReq || writeReq) |-> !outstanding)
    else $error("New request issued before the previous one was acknowledged");

endmodule

bind cpuCore cpuCoreAssertions busChecks (
  .clk(clk),
  .reset(reset),
  .readReq(readReq),
  .writeReq(writeReq),
  .readAck(readAck),
  .writeAck(writeAck),
  .doutValid(doutValid)
);

`default_nettype wire

// ==== dv/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb import cpuCorePkg::*; ();

  logic clk;
  logic reset;
  wordT ramIn;
  logic readAck;
  logic writeAck;
  wordT ramAddress;
  wordT ramOut;
  logic readReq;
  logic writeReq;
  logic doutValid;
  wordT doutData;

  // 1 KB RAM model, word addressed
  wordT ram [256];

  // Ordered expected events, kind W or D
  logic [7:0] expKind [$];
  wordT       expAddr [$];
  wordT       expData [$];

  logic        allSeen = 1'b0;
  int          cycleCount = 0;
  int          cycleLimit;
  logic [31:0] rngState = 32'd23337;
  int          ackCountdown;
  logic        pending;
  logic        pendingRead;
  wordT        pendingAddr;

  cpuCore DUT (
    .clk(clk),
    .reset(reset),
    .ramIn(ramIn),
    .readAck(readAck),
    .writeAck(writeAck),
    .ramAddress(ramAddress),
    .ramOut(ramOut),
    .readReq(readReq),
    .writeReq(writeReq),
    .doutValid(doutValid),
    .doutData(doutData)
  );

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abortRun(input string reason);
    $display("Simulation FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic checkValue(input string what, input wordT got, input wordT expected);
    if (got !== expected)
    begin
      $display("Fail at %0t ns: %s is %08h, expected %08h", $time, what, got, expected);
      abortRun("Observed value differs from the golden file");
    end
  endtask

  // Compare one bus write or dout pulse with the head of the list
  task automatic matchEvent(input logic [7:0] kind, input wordT addr, input wordT data);
    if (expKind.size() == 0)
      abortRun("DUT produced a bus write or dout pulse after the expected list ended");
    else
    begin
      checkValue("event kind", {24'h0, kind}, {24'h0, expKind[0]});
      if (kind == "W")
      begin
        checkValue("write address", addr, expAddr[0]);
        checkValue("write data", data, expData[0]);
      end
      else
        checkValue("dout data", data, expData[0]);
      void'(expKind.pop_front());
      void'(expAddr.pop_front());
      void'(expData.pop_front());
      if (expKind.size() == 0)
        allSeen = 1'b1;
    end
  endtask

  task automatic loadGolden();
    int            fd;
    int            code;
    logic [7:0]    kind;
    wordT          a;
    wordT          w0;
    wordT          w1;
    logic [1023:0] restLine;
    logic          done;
    // Fill pattern carries the word index
    for (int i = 0; i < 256; i++)
      ram[i[7:0]] = 32'hBAD00000 | i;
    fd = $fopen("dv/cpuCore_golden.txt", "r");
    if (fd == 0)
      abortRun("Could not open dv/cpuCore_golden.txt");
    done = 1'b0;
    while (!done)
    begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1)
        done = 1'b1;
      else if (kind == "#")
        code = $fgets(restLine, fd);
      else if (kind == "M")
      begin
        // Two consecutive words per line
        code = $fscanf(fd, " %h %h %h", a, w0, w1);
        if (code != 3)
          abortRun("Malformed M line in golden file");
        ram[a[9:2]] = w0;
        ram[a[9:2] + 8'd1] = w1;
      end
      else if (kind == "W")
      begin
        code = $fscanf(fd, " %h %h", a, w0);
        if (code != 2)
          abortRun("Malformed W line in golden file");
        expKind.push_back("W");
        expAddr.push_back(a);
        expData.push_back(w0);
      end
      else if (kind == "D")
      begin
        code = $fscanf(fd, " %h", w0);
        if (code != 1)
          abortRun("Malformed D line in golden file");
        expKind.push_back("D");
        expAddr.push_back('0);
        expData.push_back(w0);
      end
      else
        abortRun("Unknown line kind in golden file");
    end
    $fclose(fd);
    if (expKind.size() == 0)
      abortRun("Golden file holds no expected events");
  endtask

  // RAM model and event monitor
  initial
  begin
    ramIn    <= '0;
    readAck  <= 1'b0;
    writeAck <= 1'b0;
    pending = 1'b0;
    loadGolden();
    forever
    begin
      @(posedge clk);
      readAck  <= 1'b0;
      writeAck <= 1'b0;
      if (reset)
        pending = 1'b0;
      else
      begin
        // Acknowledge 1 to 4 cycles after the request
        if (pending)
        begin
          if (ackCountdown == 1)
          begin
            pending = 1'b0;
            if (pendingRead)
            begin
              readAck <= 1'b1;
              ramIn   <= ram[pendingAddr[9:2]];
            end
            else
              writeAck <= 1'b1;
          end
          else
            ackCountdown = ackCountdown - 1;
        end
        if (readReq || writeReq)
        begin
          rngState = xorshift32(rngState);
          ackCountdown = int'(rngState % 32'd4) + 1;
          pending = 1'b1;
          pendingRead = readReq;
          pendingAddr = ramAddress;
          if (writeReq)
          begin
            ram[ramAddress[9:2]] = ramOut;
            matchEvent("W", ramAddress, ramOut);
          end
        end
        if (doutValid)
          matchEvent("D", '0, doutData);
      end
    end
  end

  // Reset, then run until the list is used up or time runs out
  initial
  begin
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // 60 cycles per expected event
    cycleLimit = 60 * expKind.size();
    while (!allSeen && (cycleCount < cycleLimit))
      @(posedge clk);
    if (allSeen)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
      abortRun("Timed out before all expected writes and dout pulses were seen");
  end

endmodule

`default_nettype wire

// ==== cpuCore.f ====
logic/cpuCorePkg.sv
logic/cpuIsaPkg.sv
logic/controlSequencer.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/cpuCore.sv
dv/cpuCore_assertions.sv
dv/cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim &&
./obj_dir/cpuCoreSim ||
{ echo "cpuCore simulation run did not complete cleanly"; exit 1; }

// ==== dv/cpuCore_golden.txt ====
# M addr word word: two consecutive RAM words starting at byte address addr
# W addr data: expected bus write. D data: expected dout pulse. Listed in order
# Arithmetic: MovRC AddRC AddRR IncR DecR MulAddRRC
M 00000000 00000001 00000300
M 00000008 00000201 00000015
M 00000010 00000215 00000210
M 00000018 00000100 00000215
M 00000020 00000301 00000007
M 00000028 00030211 00000215
M 00000030 00000312 00000315
M 00000038 00000213 00000215
M 00000040 00020314 00000010
M 00000048 00000315 00000401
M 00000050 12345678 00040414
M 00000058 00000100 00000415
# Stores and loads
M 00000060 00020006 00000200
M 00000068 00000501 00000200
M 00000070 00030507 00000008
M 00000078 00000603 00000200
M 00000080 00000615 00050705
M 00000088 00000008 00000715
M 00000090 00000901 0000020C
M 00000098 00090804 00000815
M 000000A0 00080A02 00000A15
# Push, pop, call
M 000000A8 00000208 00000408
M 000000B0 00000B09 00000C09
M 000000B8 00000B15 00000C15
M 000000C0 00000D01 00000180
M 000000C8 00000D0A 00000415
# Countdown loop, compares, skipping jump, idle loop
M 000000D0 00000E01 00000003
M 000000D8 00000E15 00000E13
M 000000E0 00000E0D 00000000
M 000000E8 0000000F 000000D8
M 000000F0 00000115 0003020C
M 000000F8 00000115 0002030C
M 00000100 00000115 0000000E
M 00000108 00000110 00000815
M 00000110 00000E15 0000000E
M 00000118 00000114 00000000
# Callee and preloaded data word
M 00000180 00000315 0000000B
M 0000020C CAFEF00D 00000000
# Expected events
D 00000015
D 00000115
D 0000011C
D 00000008
D 0000011B
D 000011B8
D 468ACE78
W 00000200 0000011B
W 00000208 000011B8
D 0000011B
D 000011B8
D CAFEF00D
D CAFEF00D
W 00000300 0000011B
W 00000304 468ACE78
D 468ACE78
D 0000011B
W 00000300 000000C8
D 000011B8
D 468ACE78
D 00000003
D 00000002
D 00000001
D 00000001
D 00000002
D 00000004
D 00000000
